/* cpu_top.sv */
// five-stage in-order rv32i subset core
// program is loaded through the imem port while reset is high
// is_halted rises when the halting ecall reaches writeback and stays high
`timescale 1ns/1ps

module cpu_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               imem_we,
  input  rv_pkg::imem_addr_t imem_addr,
  input  rv_pkg::word_t      imem_data,
  input  rv_pkg::reg_idx_t   dbg_addr,
  output rv_pkg::word_t      dbg_data,
  output logic               is_halted
);
  import rv_pkg::*;

  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  mem_wb_t  mem_wb;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     is_ecall;
  logic     stall;
  logic     byp_rs1;
  logic     byp_rs2;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  fwd_sel_e fwd_ecall;
  logic     redirect;
  word_t    redirect_pc;
  word_t    alu_fwd;

  fetch_stage i_fetch_stage (
    .clk         (clk),
    .reset       (reset),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (is_halted),
    .if_id       (if_id)
  );

  decode_stage i_decode_stage (
    .clk       (clk),
    .reset     (reset),
    .if_id     (if_id),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .fwd_ecall (fwd_ecall),
    .mem_fwd   (alu_fwd),
    .wb_fwd    (mem_wb.wb_data),  // writeback value
    .byp_rs1   (byp_rs1),
    .byp_rs2   (byp_rs2),
    .stall     (stall),
    .redirect  (redirect),
    .rs1       (rs1),
    .rs2       (rs2),
    .is_ecall  (is_ecall),
    .id_ex     (id_ex)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .dbg_addr (dbg_addr),
    .wr       (mem_wb),  // write port driven by writeback
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_data)
  );

  hazard_unit i_hazard_unit (
    .rs1       (rs1),
    .rs2       (rs2),
    .is_ecall  (is_ecall),
    .id_ex     (id_ex),
    .ex_mem    (ex_mem),
    .mem_wb    (mem_wb),
    .stall     (stall),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b),
    .fwd_ecall (fwd_ecall),
    .byp_rs1   (byp_rs1),
    .byp_rs2   (byp_rs2)
  );

  execute_stage i_execute_stage (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .mem_wb      (mem_wb),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .alu_fwd     (alu_fwd)
  );

  memory_stage i_memory_stage (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_wb    (mem_wb),
    .is_halted (is_halted)
  );

endmodule

/* decode_stage.sv */
// opcode decode, immediates, ecall halt check and the id/ex register
// ecall reads x17 through rs1; x17 == 10 halts, any other value is a no-op
// unknown opcodes decode as no-ops; stall or redirect puts a bubble in id/ex
`timescale 1ns/1ps

module decode_stage (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::if_id_t   if_id,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::fwd_sel_e fwd_ecall,
  input  rv_pkg::word_t    mem_fwd,
  input  rv_pkg::word_t    wb_fwd,
  input  logic             byp_rs1,
  input  logic             byp_rs2,
  input  logic             stall,
  input  logic             redirect,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output logic             is_ecall,
  output rv_pkg::id_ex_t   id_ex
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  ctrl_t      ctrl;
  alu_op_e    alu_op;
  word_t      imm;
  word_t      x17_val;
  word_t      rs1_val;
  word_t      rs2_val;

  assign opcode   = if_id.inst[6:0];
  assign funct3   = if_id.inst[14:12];
  assign is_ecall = if_id.valid && opcode == OP_SYSTEM;
  assign rs1      = is_ecall ? ECALL_REG : if_id.inst[19:15];  // steer to a7
  assign rs2      = if_id.inst[24:20];
  assign rs1_val  = byp_rs1 ? wb_fwd : rs1_data;  // same-cycle writeback
  assign rs2_val  = byp_rs2 ? wb_fwd : rs2_data;

  always_comb begin
    case (fwd_ecall)
      FWD_MEM: x17_val = mem_fwd;
      FWD_WB:  x17_val = wb_fwd;
      default: x17_val = rs1_data;  // rs1 already points at x17
    endcase
  end

  always_comb begin
    ctrl   = '0;
    alu_op = ALU_ADD;
    imm    = {{20{if_id.inst[31]}}, if_id.inst[31:20]};  // I form
    case (opcode)
      OP_R: begin
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = if_id.inst[30] ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b101:  alu_op = ALU_SRL;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      OP_I: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        case (funct3)
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;  // addi
        endcase
      end
      OP_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
      end
      OP_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];  // bne
        imm = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
               if_id.inst[30:25], if_id.inst[11:8], 1'b0};
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        imm = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
               if_id.inst[20], if_id.inst[30:21], 1'b0};
      end
      OP_SYSTEM: ctrl.halt = x17_val == HALT_CODE;  // ecall exit check
      default: ctrl = '0;
    endcase
    if (!if_id.valid) begin
      ctrl = '0;  // flushed slot
    end
  end

  always_ff @(posedge clk) begin
    if (reset || stall || redirect) begin
      id_ex.ctrl <= '0;  // bubble
    end else begin
      id_ex.ctrl <= ctrl;
    end
    id_ex.alu_op   <= alu_op;
    id_ex.pc       <= if_id.pc;
    id_ex.rs1_data <= rs1_val;
    id_ex.rs2_data <= rs2_val;
    id_ex.imm      <= imm;
    id_ex.rs1      <= rs1;
    id_ex.rs2      <= rs2;
    id_ex.rd       <= if_id.inst[11:7];
  end

endmodule

/* execute_stage.sv */
// ALU, operand forwarding, branch and jal resolution, ex/mem register
// branches resolve here; a taken branch or jal redirects fetch to pc+imm
// and costs the two younger slots
`timescale 1ns/1ps

module execute_stage (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::id_ex_t   id_ex,
  input  rv_pkg::fwd_sel_e fwd_a,
  input  rv_pkg::fwd_sel_e fwd_b,
  input  rv_pkg::mem_wb_t  mem_wb,
  output rv_pkg::ex_mem_t  ex_mem,
  output logic             redirect,
  output rv_pkg::word_t    redirect_pc,
  output rv_pkg::word_t    alu_fwd
);
  import rv_pkg::*;

  word_t op_a;
  word_t fwd_b_val;
  word_t op_b;
  word_t alu_out;
  word_t link_pc;
  logic  equal;

  // value a younger op sees from MEM; jal writes its link
  assign alu_fwd = ex_mem.ctrl.jal ? ex_mem.link_pc : ex_mem.alu_out;

  always_comb begin
    case (fwd_a)
      FWD_MEM: op_a = alu_fwd;
      FWD_WB:  op_a = mem_wb.wb_data;
      default: op_a = id_ex.rs1_data;
    endcase
    case (fwd_b)
      FWD_MEM: fwd_b_val = alu_fwd;
      FWD_WB:  fwd_b_val = mem_wb.wb_data;
      default: fwd_b_val = id_ex.rs2_data;
    endcase
  end

  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b_val;  // imm for I/load/store

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD: alu_out = op_a + op_b;
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_XOR: alu_out = op_a ^ op_b;
      ALU_SLT: alu_out = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLL: alu_out = op_a << op_b[4:0];
      ALU_SRL: alu_out = op_a >> op_b[4:0];
      default: alu_out = op_a + op_b;
    endcase
  end

  assign equal       = op_a == fwd_b_val;     // beq compare
  assign redirect    = id_ex.ctrl.jal ||
                       (id_ex.ctrl.branch && (equal ^ id_ex.ctrl.branch_ne));
  assign redirect_pc = id_ex.pc + id_ex.imm;  // B or J offset
  assign link_pc     = id_ex.pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.ctrl <= '0;
    end else begin
      ex_mem.ctrl <= id_ex.ctrl;
    end
    ex_mem.alu_out    <= alu_out;
    ex_mem.store_data <= fwd_b_val;  // sw data, forwarded
    ex_mem.link_pc    <= link_pc;
    ex_mem.rd         <= id_ex.rd;
  end

endmodule

/* fetch_stage.sv */
// pc, instruction memory and the if/id register
// imem loads are taken only while reset is high; the pc wraps past IMEM_WORDS
// always predicts pc+4, a redirect from EX overrides it and beats a stall
`timescale 1ns/1ps

module fetch_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               imem_we,
  input  rv_pkg::imem_addr_t imem_addr,
  input  rv_pkg::word_t      imem_data,
  input  logic               stall,
  input  logic               redirect,
  input  rv_pkg::word_t      redirect_pc,
  input  logic               halted,
  output rv_pkg::if_id_t     if_id
);
  import rv_pkg::*;

  word_t      imem [IMEM_WORDS];
  word_t      pc;
  imem_addr_t pc_idx;
  word_t      inst;

  assign pc_idx = pc[$bits(imem_addr_t)+1:2];  // word index
  assign inst   = imem[pc_idx];                // async read

  always_ff @(posedge clk) begin
    if (reset && imem_we) begin  // program load port
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!halted) begin  // frozen once the core halts
      if (redirect) begin
        pc <= redirect_pc;       // taken branch or jal
      end else if (!stall) begin
        pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      if_id.valid <= 1'b0;
    end else if (redirect) begin
      if_id.valid <= 1'b0;       // squash wrong-path fetch
    end else if (!stall && !halted) begin
      if_id <= '{valid: 1'b1, pc: pc, inst: inst};
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);
  a_load_in_reset: assert property (@(posedge clk)
    imem_we |-> reset);

endmodule

/* hazard_unit.sv */
// load-use stall, EX forwarding selects and the decode-side bypasses
// MEM wins over WB; register 0 is never forwarded
// ecall waits while x17 is still being produced in EX, or loaded in MEM
`timescale 1ns/1ps

module hazard_unit (
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             is_ecall,
  input  rv_pkg::id_ex_t   id_ex,
  input  rv_pkg::ex_mem_t  ex_mem,
  input  rv_pkg::mem_wb_t  mem_wb,
  output logic             stall,
  output rv_pkg::fwd_sel_e fwd_a,
  output rv_pkg::fwd_sel_e fwd_b,
  output rv_pkg::fwd_sel_e fwd_ecall,
  output logic             byp_rs1,
  output logic             byp_rs2
);
  import rv_pkg::*;

  logic load_use;
  logic ecall_wait;

  function automatic fwd_sel_e pick(reg_idx_t src, ex_mem_t em, mem_wb_t mw);
    fwd_sel_e sel;
    sel = FWD_RF;
    if (mw.reg_write && mw.rd == src) begin
      sel = FWD_WB;
    end
    if (em.ctrl.reg_write && em.rd == src) begin
      sel = FWD_MEM;  // newer value
    end
    if (src == '0) begin
      sel = FWD_RF;
    end
    return sel;
  endfunction

  assign fwd_a     = pick(id_ex.rs1, ex_mem, mem_wb);
  assign fwd_b     = pick(id_ex.rs2, ex_mem, mem_wb);
  assign fwd_ecall = pick(ECALL_REG, ex_mem, mem_wb);

  assign byp_rs1 = mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == rs1;
  assign byp_rs2 = mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == rs2;

  assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                    (id_ex.rd == rs1 || (!is_ecall && id_ex.rd == rs2));  // ecall reads rs1 only
  assign ecall_wait = is_ecall &&
                      ((id_ex.ctrl.reg_write && id_ex.rd == ECALL_REG) ||
                       (ex_mem.ctrl.mem_read && ex_mem.rd == ECALL_REG));
  assign stall = load_use || ecall_wait;

endmodule

/* memory_stage.sv */
// data memory, writeback select and the mem/wb register
// dmem is word addressed by alu_out[7:2]; higher address bits are ignored
// after the halting ecall reaches mem/wb, later ops write nothing
`timescale 1ns/1ps

module memory_stage (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::ex_mem_t ex_mem,
  output rv_pkg::mem_wb_t mem_wb,
  output logic            is_halted
);
  import rv_pkg::*;

  word_t      dmem [DMEM_WORDS];
  dmem_addr_t addr;
  word_t      rdata;
  word_t      wb_data;
  logic       halted_q;

  assign addr      = ex_mem.alu_out[$bits(dmem_addr_t)+1:2];
  assign rdata     = dmem[addr];                // async read
  assign is_halted = mem_wb.halt || halted_q;   // sticky
  assign wb_data   = ex_mem.ctrl.jal        ? ex_mem.link_pc :
                     ex_mem.ctrl.mem_to_reg ? rdata : ex_mem.alu_out;

  always_ff @(posedge clk) begin
    if (ex_mem.ctrl.mem_write && !is_halted) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.reg_write <= 1'b0;
      mem_wb.halt      <= 1'b0;
      halted_q         <= 1'b0;
    end else begin
      mem_wb.reg_write <= ex_mem.ctrl.reg_write && !is_halted;  // squash younger ops
      mem_wb.halt      <= ex_mem.ctrl.halt && !is_halted;
      halted_q         <= is_halted;
    end
    mem_wb.wb_data <= wb_data;
    mem_wb.rd      <= ex_mem.rd;
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write));

endmodule

/* project.f */
+incdir+.
rv_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

/* reg_file.sv */
// 32 x 32 register file, two async read ports plus a debug read port
// reads do not return a same-cycle write; decode bypasses that case
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t dbg_addr,
  input  rv_pkg::mem_wb_t  wr,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    dbg_data
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.reg_write && wr.rd != '0) begin  // x0 never written
      regs[wr.rd] <= wr.wb_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign dbg_data = regs[dbg_addr];  // testbench view

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    regs[0] == '0);

endmodule

/* rv_pkg.sv */
// shared widths, opcodes, enums and pipeline register structs for the core
// rv32i subset only: no jalr, no byte or halfword access, no shifts by immediate
// both memories are word addressed, 64 words each
package rv_pkg;

  localparam int XLEN       = 32;  // data width
  localparam int IMEM_WORDS = 64;  // instruction memory depth
  localparam int DMEM_WORDS = 64;  // data memory depth

  typedef logic [XLEN-1:0]                 word_t;       // data or instruction word
  typedef logic [4:0]                      reg_idx_t;    // register index
  typedef logic [$clog2(IMEM_WORDS)-1:0]   imem_addr_t;  // instruction word address
  typedef logic [$clog2(DMEM_WORDS)-1:0]   dmem_addr_t;  // data word address

  localparam reg_idx_t ECALL_REG = 5'd17;  // a7 carries the ecall code
  localparam word_t    HALT_CODE = 32'd10; // exit request

  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,  // signed
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_RF,   // value read in decode
    FWD_MEM,  // from ex/mem
    FWD_WB    // from mem/wb
  } fwd_sel_e;

  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic mem_to_reg;
    logic alu_src;    // operand b is the immediate
    logic branch;
    logic branch_ne;  // bne, inverts the compare
    logic jal;
    logic halt;       // ecall with x17 == 10
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    alu_op_e  alu_op;
    word_t    pc;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_out;
    word_t    store_data;
    word_t    link_pc;    // pc+4 for jal
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_write;
    logic     halt;
    word_t    wb_data;
    reg_idx_t rd;
  } mem_wb_t;

endpackage

/* tb_iss.svh */
// instruction-set model, random program generator and lfsr, included inside tb_cpu
// programs are 40 words: data base preamble, random body, then x17 = 10 and ecall
// x1 is the data base (64) and never a random destination; x17 is only set != 10
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

localparam int PROG_LEN = 40;
localparam logic [6:0] OPC_R     = 7'h33;
localparam logic [6:0] OPC_I     = 7'h13;
localparam logic [6:0] OPC_LOAD  = 7'h03;
localparam logic [6:0] OPC_STORE = 7'h23;
localparam logic [6:0] OPC_BR    = 7'h63;
localparam logic [6:0] OPC_JAL   = 7'h6f;
localparam logic [31:0] ECALL    = 32'h00000073;

logic [31:0] lfsr = 32'hf93e3f5c;
logic [31:0] prog [PROG_LEN];
logic [31:0] exp_regs [32];
logic [31:0] model_dmem [64] = '{default: '0};  // persists like the dut dmem

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++) begin
    v    = {v[30:0], lfsr[0]};
    lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
  end
  return v;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_R};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // sw
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BR};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// unused imem words: addi x0, x0, word index
function automatic logic [31:0] fill_word(input int a);
  return enc_i(12'(a), 5'd0, 3'b000, 5'd0, OPC_I);
endfunction

task automatic build_program();
  logic [3:0] kind;
  logic [2:0] sel;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [2:0] f3;
  int         off;
  prog[0] = enc_i(12'd64, 5'd0, 3'b000, 5'd1, OPC_I);  // x1 = data base
  for (int k = 1; k < 5; k++) begin
    prog[k] = enc_s(12'(4 * (k - 1)), 5'd0, 5'd1);    // clear the four data words
  end
  for (int i = 5; i < PROG_LEN - 2; i++) begin
    kind = 4'(rand_bits(4));
    rd   = 5'(rand_bits(3));
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    if (rd == 5'd1) rd = 5'd9;  // keep base intact, x0 allowed
    off = 1 + int'(rand_bits(3));
    if (i + off > PROG_LEN - 2) off = PROG_LEN - 2 - i;  // never skip the halt tail
    if (kind < 5) begin
      sel = 3'(rand_bits(3));
      f3  = (sel == 0 || sel == 1) ? 3'b000 : (sel == 2) ? 3'b001 :
            (sel == 3) ? 3'b010 : sel;  // add sub sll slt xor srl or and
      prog[i] = enc_r((sel == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    end else if (kind < 8) begin
      sel = 3'(rand_bits(3) % 5);
      f3  = (sel == 0) ? 3'b000 : (sel == 1) ? 3'b010 : (sel == 2) ? 3'b100 :
            (sel == 3) ? 3'b110 : 3'b111;
      prog[i] = enc_i(12'(rand_bits(12)), rs1, f3, rd, OPC_I);
    end else if (kind < 10) begin
      prog[i] = enc_i(12'(4 * rand_bits(2)), 5'd1, 3'b010, rd, OPC_LOAD);  // lw
    end else if (kind < 12) begin
      prog[i] = enc_s(12'(4 * rand_bits(2)), rs2, 5'd1);
    end else if (kind == 12) begin
      prog[i] = enc_b(13'(4 * off), rs2, rs1, {2'b00, rand_bits(1) == 1});  // beq or bne
    end else if (kind == 13) begin
      prog[i] = enc_j(21'(4 * off), rd);
    end else if (kind == 14) begin
      f3 = 3'(rand_bits(3));
      prog[i] = enc_i((f3 == 3'd2) ? 12'd11 : 12'(f3 + 8), 5'd0, 3'b000, 5'd17, OPC_I);
    end else begin
      prog[i] = ECALL;  // x17 is never 10 here
    end
  end
  prog[PROG_LEN-2] = enc_i(12'd10, 5'd0, 3'b000, 5'd17, OPC_I);
  prog[PROG_LEN-1] = ECALL;
endtask

// sequential reference, stops at the halting ecall
task automatic run_model();
  logic [31:0] pc;
  logic [31:0] nxt;
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] addr;
  logic [31:0] res;
  logic        wr;
  logic        done;
  int          steps;
  foreach (exp_regs[r]) exp_regs[r] = '0;
  pc    = '0;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < 4 * PROG_LEN) begin
    inst  = prog[pc >> 2];
    a     = exp_regs[inst[19:15]];
    b     = exp_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    nxt   = pc + 4;
    wr    = 1'b0;
    res   = '0;
    case (inst[6:0])
      OPC_R, OPC_I: begin
        if (inst[6:0] == OPC_I) b = imm_i;
        wr = 1'b1;
        case (inst[14:12])
          3'b000: res = (inst[6:0] == OPC_R && inst[30]) ? a - b : a + b;
          3'b001: res = a << b[4:0];
          3'b010: res = {31'd0, $signed(a) < $signed(b)};
          3'b100: res = a ^ b;
          3'b101: res = a >> b[4:0];
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      OPC_LOAD: begin
        addr = a + imm_i;
        res  = model_dmem[addr[7:2]];
        wr   = 1'b1;
      end
      OPC_STORE: begin
        addr = a + imm_s;
        model_dmem[addr[7:2]] = b;
      end
      OPC_BR: begin
        if ((a == b) ^ inst[12]) begin
          nxt = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        res = pc + 4;  // link
        wr  = 1'b1;
        nxt = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h73: done = (exp_regs[17] == 32'd10);
      default: ;
    endcase
    if (wr && inst[11:7] != 5'd0) exp_regs[inst[11:7]] = res;
    pc    = nxt;
    steps = steps + 1;
  end
endtask

`endif

/* tb_cpu.sv */
// random-program testbench for cpu_top, checked against the model in tb_iss.svh
// each program gets its own reset; imem is loaded while reset is high
// run length bounded by a cycle watchdog sized from the program length
`timescale 1ns/1ps

module tb_cpu;

  `include "tb_iss.svh"

  localparam int NUM_PROGS      = 5;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 3 + 20);

  logic        clk = 1'b0;
  logic        reset;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_data;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;
  logic        is_halted;

  logic running = 1'b0;  // watchdog counts only while a program runs
  int   run_cycles = 0;
  int   test_errors;
  int   halt_cycles;
  int   passed = 0;
  int   failed = 0;

  cpu_top i_cpu_top (
    .clk       (clk),
    .reset     (reset),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .is_halted (is_halted)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) begin
    if (running) begin
      run_cycles = run_cycles + 1;  // summed over all programs
      if (run_cycles > TIMEOUT_CYCLES) begin
        $display("halt never reached within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
      end
    end
  end

  // whole imem every time, program then fill
  task automatic load_program();
    for (int a = 0; a < 64; a++) begin
      @(negedge clk);
      imem_we   = 1'b1;
      imem_addr = 6'(a);
      imem_data = (a < PROG_LEN) ? prog[a] : fill_word(a);
    end
    @(negedge clk);
    imem_we = 1'b0;
  endtask

  // still in reset: registers clear, not halted
  task automatic check_reset_state();
    for (int r = 0; r < 32; r++) begin
      @(negedge clk);
      dbg_addr = 5'(r);
      @(negedge clk);
      assert (dbg_data === 32'd0) else begin
        $display("MISMATCH %0t dbg_data[x%0d] got %h expected %h", $time, r, dbg_data, 32'd0);
        test_errors++;
      end
      assert (is_halted === 1'b0) else begin
        $display("MISMATCH %0t is_halted got %b expected 0", $time, is_halted);
        test_errors++;
      end
    end
  endtask

  task automatic wait_for_halt();
    halt_cycles = 0;
    while (is_halted !== 1'b1) begin
      @(negedge clk);
      halt_cycles++;
    end
  endtask

  // halt must hold through every read
  task automatic compare_registers();
    logic [31:0] expected;
    for (int r = 0; r < 32; r++) begin
      expected = (r == 0) ? 32'd0 : exp_regs[r];  // x0 even when targeted
      @(negedge clk);
      dbg_addr = 5'(r);
      @(negedge clk);
      assert (dbg_data === expected) else begin
        $display("MISMATCH %0t dbg_data[x%0d] got %h expected %h", $time, r, dbg_data, expected);
        test_errors++;
      end
      assert (is_halted === 1'b1) else begin
        $display("MISMATCH %0t is_halted got %b expected 1", $time, is_halted);
        test_errors++;
      end
    end
  endtask

  initial begin
    reset     = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    dbg_addr  = '0;
    for (int t = 0; t < NUM_PROGS; t++) begin
      test_errors = 0;
      @(negedge clk);
      reset = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      build_program();
      run_model();
      load_program();
      check_reset_state();
      @(negedge clk);
      reset   = 1'b0;
      running = 1'b1;
      wait_for_halt();
      running = 1'b0;
      compare_registers();
      if (test_errors == 0) passed++;
      else failed++;
      $display("program %0d: %s, halted after %0d cycles, %0d errors", t,
               (test_errors == 0) ? "pass" : "FAIL", halt_cycles, test_errors);
    end
    $display("programs passed %0d, programs failed %0d", passed, failed);
    if (failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
